// ==== Bender.yml ====
package:
  name: scan_dma

sources:
  - scan_pkg.sv
  - sync_fifo.sv
  - pixel_packer.sv
  - beat_assembler.sv
  - dma_writer.sv
  - scan_dma_top.sv
  - target: test
    files:
      - tb_scan_dma.sv

// ==== beat_assembler.sv ====
`timescale 1ns/10ps

module beat_assembler import scan_pkg::*;
(
    input  logic        w_bus_clk,
    input  logic        w_adc_rst,
    input  word_t       word_dout,
    input  logic        word_empty,
    input  logic        beat_full,
    output logic        word_pop,
    output beat_t       beat_din,
    output logic        beat_push
);

logic [WCNT_W-1:0]  word_cnt;       // words already held
logic               last_word;
beat_t              beat_acc;

assign last_word = (word_cnt == WCNT_W'(WORDS_PER_BEAT - 1));

// only the closing word waits for room in the beat fifo
assign word_pop  = !word_empty && !(last_word && beat_full);
assign beat_push = word_pop && last_word;

// held words sit in the upper slots, first word ends up lowest
assign beat_din  = {word_dout, beat_acc[BEAT_W-1:WORD_W]};

always_ff @(posedge w_bus_clk)
begin
    if (w_adc_rst)
        word_cnt <= '0;
    else if (word_pop)
        word_cnt <= last_word ? '0 : word_cnt + 1'b1;
end

always_ff @(posedge w_bus_clk)
begin
    if (word_pop)
        beat_acc <= {word_dout, beat_acc[BEAT_W-1:WORD_W]};    // shift right
end

endmodule

// ==== dma_writer.sv ====
`timescale 1ns/10ps

module dma_writer import scan_pkg::*;
(
    input  logic        w_bus_clk,
    input  logic        w_adc_rst,
    input  logic        dma_on,
    input  sdram_adr_t  dma_start_adr,
    input  sdram_adr_t  dma_buf_size,
    input  beat_t       beat_dout,
    input  logic        beat_empty,
    input  logic        sdram_waitrequest,
    output logic        beat_pop,
    output sdram_adr_t  sdram_address,
    output beat_t       sdram_writedata,
    output logic        sdram_write,
    output done_cnt_t   dma_done_cnt
);

typedef enum logic
{
    ST_IDLE  = 1'b0,
    ST_WRITE = 1'b1
} dma_state_t;

dma_state_t     state;
sdram_adr_t     offset;             // ring position of the next beat
sdram_adr_t     cur_off;
sdram_adr_t     next_off;
logic           dma_on_q;
logic           dma_rise;
logic           load;
logic           accept;
logic           last_beat;          // beat in flight closes a pass

////////////////////////////////////////////////////////////////////////////
// ring offset

assign dma_rise = dma_on && !dma_on_q;
assign cur_off  = dma_rise ? '0 : offset;       // restart at the buffer base
assign next_off = (cur_off == dma_buf_size - 1'b1) ? '0 : cur_off + 1'b1;

assign load        = (state == ST_IDLE) && dma_on && !beat_empty;
assign accept      = sdram_write && !sdram_waitrequest;
assign beat_pop    = load;
assign sdram_write = (state == ST_WRITE);

always_ff @(posedge w_bus_clk)
begin
    if (w_adc_rst)
    begin
        state        <= ST_IDLE;
        offset       <= '0;
        dma_on_q     <= 1'b0;
        dma_done_cnt <= '0;
    end
    else
    begin
        dma_on_q <= dma_on;
        case (state)
            ST_IDLE:
                if (load)
                    state <= ST_WRITE;
            ST_WRITE:
                if (accept)
                    state <= ST_IDLE;   // dma_on low stops after this beat
            default:
                state <= ST_IDLE;
        endcase
        if (load)
            offset <= next_off;
        else if (dma_rise)
            offset <= '0;
        if (accept && last_beat)
            dma_done_cnt <= dma_done_cnt + 1'b1;
    end
end

// write register, loaded together with the pop
always_ff @(posedge w_bus_clk)
begin
    if (load)
    begin
        sdram_address   <= dma_start_adr + cur_off;
        sdram_writedata <= beat_dout;
        last_beat       <= (cur_off == dma_buf_size - 1'b1);
    end
end

a_hold_on_wait : assert property (
    @(posedge w_bus_clk) disable iff (w_adc_rst)
    (sdram_write && sdram_waitrequest) |=>
        (sdram_write && $stable(sdram_address) && $stable(sdram_writedata)))
    else $error("sdram request changed under waitrequest");

endmodule

// ==== pixel_packer.sv ====
`timescale 1ns/10ps

module pixel_packer import scan_pkg::*;
(
    input  logic        w_bus_clk,
    input  logic        w_adc_rst,
    input  adc_t        adc_data,
    input  logic        adc_valid,
    input  test_mode_t  test_mode,
    input  logic        word_full,
    output word_t       pix_word,
    output logic        pix_push,
    output logic        pix_ovr
);

logic [LANE_W-1:0]  lane;           // next byte lane to fill
logic               last_pix;
pix_t               pix;
pix_t               ramp_cnt;
logic               odd_sample;
word_t              word_acc;
word_t              word_next;

////////////////////////////////////////////////////////////////////////////
// pixel select

always_comb
begin
    case (test_mode)
        MODE_ADC:     pix = adc_data[ADC_W-1 -: PIX_W];    // drop the 4 lsbs
        MODE_RAMP:    pix = ramp_cnt;
        MODE_CHECKER: pix = odd_sample ? pix_t'(8'hAA) : pix_t'(8'h55);
        default:      pix = '0;
    endcase
end

assign last_pix = (lane == LANE_W'(PIX_PER_WORD - 1));

// first pixel lands in the low byte
always_comb
begin
    word_next = word_acc;
    word_next[lane*PIX_W +: PIX_W] = pix;
end

////////////////////////////////////////////////////////////////////////////
// lane counter, test generators, push and overflow

always_ff @(posedge w_bus_clk)
begin
    if (w_adc_rst)
    begin
        lane       <= '0;
        ramp_cnt   <= '0;
        odd_sample <= 1'b0;
        pix_push   <= 1'b0;
        pix_ovr    <= 1'b0;
    end
    else
    begin
        pix_push <= 1'b0;
        if (adc_valid)
        begin
            lane       <= last_pix ? '0 : lane + 1'b1;
            odd_sample <= ~odd_sample;                  // every accepted sample
            if (test_mode == MODE_RAMP)
                ramp_cnt <= ramp_cnt + 1'b1;
            if (last_pix)
            begin
                if (word_full)
                    pix_ovr <= 1'b1;                    // sticky until reset
                else
                    pix_push <= 1'b1;
            end
        end
    end
end

always_ff @(posedge w_bus_clk)
begin
    if (adc_valid)
    begin
        word_acc <= word_next;
        if (last_pix)
            pix_word <= word_next;
    end
end

// full may only fall between the decision and the push
a_no_push_on_full : assert property (
    @(posedge w_bus_clk) disable iff (w_adc_rst)
    !(pix_push && word_full))
    else $error("pixel word pushed into a full fifo");

endmodule

// ==== scan_dma_top.sv ====
`timescale 1ns/10ps

module scan_dma_top import scan_pkg::*;
(
    input  logic        w_bus_clk,
    input  logic        w_adc_rst,
    input  adc_t        adc_data,
    input  logic        adc_valid,
    input  test_mode_t  test_mode,
    input  logic        dma_on,
    input  sdram_adr_t  dma_start_adr,
    input  sdram_adr_t  dma_buf_size,
    input  logic        sdram_waitrequest,
    output logic        sdram_write,
    output sdram_adr_t  sdram_address,
    output beat_t       sdram_writedata,
    output done_cnt_t   dma_done_cnt,
    output logic        word_afull,
    output logic        pix_ovr
);

word_t  pix_word;
logic   pix_push;
word_t  word_dout;
logic   word_empty;
logic   word_full;
logic   word_pop;
beat_t  beat_din;
logic   beat_push;
beat_t  beat_dout;
logic   beat_empty;
logic   beat_full;
logic   beat_pop;

////////////////////////////////////////////////////////////////////////////
// adc samples to packed words

pixel_packer i_pixel_packer
(
    .w_bus_clk          ( w_bus_clk         ),
    .w_adc_rst          ( w_adc_rst         ),
    .adc_data           ( adc_data          ),
    .adc_valid          ( adc_valid         ),
    .test_mode          ( test_mode         ),
    .word_full          ( word_full         ),
    .pix_word           ( pix_word          ),
    .pix_push           ( pix_push          ),
    .pix_ovr            ( pix_ovr           )
);

sync_fifo
#(
    .payload_t          ( word_t            ),
    .DEPTH              ( PIX_FIFO_DEPTH    ),
    .AFULL_LEVEL        ( PIX_FIFO_AFULL    )
)
i_word_fifo
(
    .w_bus_clk          ( w_bus_clk         ),
    .w_adc_rst          ( w_adc_rst         ),
    .din                ( pix_word          ),
    .push               ( pix_push          ),
    .pop                ( word_pop          ),
    .dout               ( word_dout         ),
    .empty              ( word_empty        ),
    .full               ( word_full         ),
    .afull              ( word_afull        )
);

////////////////////////////////////////////////////////////////////////////
// words to sdram beats

beat_assembler i_beat_assembler
(
    .w_bus_clk          ( w_bus_clk         ),
    .w_adc_rst          ( w_adc_rst         ),
    .word_dout          ( word_dout         ),
    .word_empty         ( word_empty        ),
    .beat_full          ( beat_full         ),
    .word_pop           ( word_pop          ),
    .beat_din           ( beat_din          ),
    .beat_push          ( beat_push         )
);

sync_fifo
#(
    .payload_t          ( beat_t            ),
    .DEPTH              ( BEAT_FIFO_DEPTH   ),
    .AFULL_LEVEL        ( BEAT_FIFO_DEPTH   )
)
i_beat_fifo
(
    .w_bus_clk          ( w_bus_clk         ),
    .w_adc_rst          ( w_adc_rst         ),
    .din                ( beat_din          ),
    .push               ( beat_push         ),
    .pop                ( beat_pop          ),
    .dout               ( beat_dout         ),
    .empty              ( beat_empty        ),
    .full               ( beat_full         ),
    .afull              (                   )   // not needed on the beat side
);

dma_writer i_dma_writer
(
    .w_bus_clk          ( w_bus_clk         ),
    .w_adc_rst          ( w_adc_rst         ),
    .dma_on             ( dma_on            ),
    .dma_start_adr      ( dma_start_adr     ),
    .dma_buf_size       ( dma_buf_size      ),
    .beat_dout          ( beat_dout         ),
    .beat_empty         ( beat_empty        ),
    .sdram_waitrequest  ( sdram_waitrequest ),
    .beat_pop           ( beat_pop          ),
    .sdram_address      ( sdram_address     ),
    .sdram_writedata    ( sdram_writedata   ),
    .sdram_write        ( sdram_write       ),
    .dma_done_cnt       ( dma_done_cnt      )
);

endmodule

// ==== scan_pkg.sv ====
package scan_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // data path widths

    localparam int ADC_W          = 12;             // raw adc sample
    localparam int PIX_W          = 8;              // packed pixel
    localparam int PIX_PER_WORD   = 4;
    localparam int WORD_W         = PIX_W * PIX_PER_WORD;
    localparam int WORDS_PER_BEAT = 4;
    localparam int BEAT_W         = WORD_W * WORDS_PER_BEAT;
    localparam int ADR_W          = 28;             // sdram beat address
    localparam int DONE_W         = 16;             // pass counter

    localparam int LANE_W         = $clog2(PIX_PER_WORD);   // byte lane index
    localparam int WCNT_W         = $clog2(WORDS_PER_BEAT); // word slot index

    ////////////////////////////////////////////////////////////////////////////
    // buffer sizing

    localparam int PIX_FIFO_DEPTH  = 64;            // in words
    localparam int PIX_FIFO_AFULL  = 56;
    localparam int BEAT_FIFO_DEPTH = 8;             // in beats

    ////////////////////////////////////////////////////////////////////////////
    // types

    typedef logic [ADC_W-1:0]  adc_t;
    typedef logic [PIX_W-1:0]  pix_t;
    typedef logic [WORD_W-1:0] word_t;
    typedef logic [BEAT_W-1:0] beat_t;
    typedef logic [ADR_W-1:0]  sdram_adr_t;
    typedef logic [DONE_W-1:0] done_cnt_t;

    // pixel source select, the two switch bits
    typedef enum logic [1:0]
    {
        MODE_ADC     = 2'd0,    // upper bits of the sample
        MODE_RAMP    = 2'd1,    // counting bytes
        MODE_CHECKER = 2'd2,    // 55/aa by sample parity
        MODE_ZERO    = 2'd3
    } test_mode_t;

endpackage

// ==== sync_fifo.sv ====
`timescale 1ns/10ps

module sync_fifo import scan_pkg::*;
#(
    parameter type payload_t   = word_t,
    parameter int  DEPTH       = PIX_FIFO_DEPTH,
    parameter int  AFULL_LEVEL = PIX_FIFO_AFULL
)
(
    input  logic        w_bus_clk,
    input  logic        w_adc_rst,
    input  payload_t    din,
    input  logic        push,
    input  logic        pop,
    output payload_t    dout,
    output logic        empty,
    output logic        full,
    output logic        afull
);

localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
localparam int CNT_W = $clog2(DEPTH + 1);

payload_t           mem [DEPTH];
logic [PTR_W-1:0]   wr_ptr;
logic [PTR_W-1:0]   rd_ptr;
logic [CNT_W-1:0]   count;
logic [CNT_W-1:0]   count_next;

always_comb
begin
    count_next = count;
    case ({push, pop})
        2'b10:   count_next = count + 1'b1;
        2'b01:   count_next = count - 1'b1;
        default: count_next = count;            // idle or both at once
    endcase
end

always_ff @(posedge w_bus_clk)
begin
    if (push)
        mem[wr_ptr] <= din;
end

assign dout = mem[rd_ptr];                      // show-ahead head

always_ff @(posedge w_bus_clk)
begin
    if (w_adc_rst)
    begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        count  <= '0;
        empty  <= 1'b1;
        full   <= 1'b0;
        afull  <= 1'b0;
    end
    else
    begin
        if (push)
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
        if (pop)
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
        count <= count_next;
        empty <= (count_next == '0);
        full  <= (count_next == CNT_W'(DEPTH));
        afull <= (count_next >= CNT_W'(AFULL_LEVEL));
    end
end

////////////////////////////////////////////////////////////////////////////
// producer and consumer must respect the flags

a_no_overflow : assert property (
    @(posedge w_bus_clk) disable iff (w_adc_rst)
    push |-> !full)
    else $error("push while full");

a_no_underflow : assert property (
    @(posedge w_bus_clk) disable iff (w_adc_rst)
    pop |-> !empty)
    else $error("pop while empty");

endmodule

// ==== tb.f ====
scan_pkg.sv
sync_fifo.sv
pixel_packer.sv
beat_assembler.sv
dma_writer.sv
scan_dma_top.sv
tb_scan_dma.sv

// ==== tb_scan_dma.sv ====
`timescale 1ns/10ps

module tb_scan_dma import scan_pkg::*;
();

localparam int          CLK_PERIOD       = 40;
localparam int          RST_CYCLES       = 10;
localparam int unsigned SEED             = 32'h86e5;
localparam int          SAMPLES_PER_BEAT = PIX_PER_WORD * WORDS_PER_BEAT;
localparam int          TOTAL_SAMPLES    = 64 + 3 * 16 + 192 + 400;    // all tests together
localparam int          WATCHDOG_CYCLES  = TOTAL_SAMPLES * 8 + 2000;
localparam int          DRAIN_LIMIT      = 2000;

logic       w_bus_clk;
logic       w_adc_rst;
adc_t       adc_data;
logic       adc_valid;
test_mode_t test_mode;
logic       dma_on;
sdram_adr_t dma_start_adr;
sdram_adr_t dma_buf_size;
logic       sdram_waitrequest;
logic       sdram_write;
sdram_adr_t sdram_address;
beat_t      sdram_writedata;
done_cnt_t  dma_done_cnt;
logic       word_afull;
logic       pix_ovr;

pix_t        exp_pix [$];           // expected pixels in stream order
pix_t        ramp_val;
int unsigned sample_cnt;            // accepted samples since reset
beat_t       sdram_mem [sdram_adr_t];
int          accepted;
int          base_accepted;
done_cnt_t   base_done;
sdram_adr_t  cur_adr;
sdram_adr_t  cur_size;

scan_dma_top i_scan_dma_top
(
    .w_bus_clk          ( w_bus_clk         ),
    .w_adc_rst          ( w_adc_rst         ),
    .adc_data           ( adc_data          ),
    .adc_valid          ( adc_valid         ),
    .test_mode          ( test_mode         ),
    .dma_on             ( dma_on            ),
    .dma_start_adr      ( dma_start_adr     ),
    .dma_buf_size       ( dma_buf_size      ),
    .sdram_waitrequest  ( sdram_waitrequest ),
    .sdram_write        ( sdram_write       ),
    .sdram_address      ( sdram_address     ),
    .sdram_writedata    ( sdram_writedata   ),
    .dma_done_cnt       ( dma_done_cnt      ),
    .word_afull         ( word_afull        ),
    .pix_ovr            ( pix_ovr           )
);

initial
begin
    w_bus_clk = 1'b0;
    forever #(CLK_PERIOD / 2) w_bus_clk = ~w_bus_clk;
end

////////////////////////////////////////////////////////////////////////////
// sdram model

always @(negedge w_bus_clk)
    sdram_waitrequest = (($urandom % 3) == 0);      // busy about a third of cycles

always @(posedge w_bus_clk)
begin
    if (!w_adc_rst && sdram_write && !sdram_waitrequest)
    begin
        sdram_mem[sdram_address] = sdram_writedata;
        accepted++;
    end
end

////////////////////////////////////////////////////////////////////////////
// helpers

task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped");
endtask

task automatic check_value(input string name, input logic [BEAT_W-1:0] got,
                           input logic [BEAT_W-1:0] exp);
    if (got !== exp)
        abort_run($sformatf("ERROR %s got 0x%0h expected 0x%0h", name, got, exp));
endtask

task automatic idle_cycles(input int n);
    repeat (n) @(negedge w_bus_clk);
endtask

task automatic apply_reset();
    @(negedge w_bus_clk);
    w_adc_rst = 1'b1;
    adc_valid = 1'b0;
    dma_on    = 1'b0;
    repeat (RST_CYCLES) @(negedge w_bus_clk);
    w_adc_rst  = 1'b0;
    exp_pix.delete();
    ramp_val   = '0;
    sample_cnt = 0;
endtask

task automatic record_pixel(input adc_t data);
    pix_t p;
    case (test_mode)
        MODE_ADC:     p = pix_t'(data >> (ADC_W - PIX_W));
        MODE_RAMP:    p = ramp_val;
        MODE_CHECKER: p = (sample_cnt % 2) ? 8'hAA : 8'h55;
        default:      p = '0;
    endcase
    if (test_mode == MODE_RAMP)
        ramp_val++;
    sample_cnt++;
    exp_pix.push_back(p);
endtask

task automatic send_samples(input int n);
    adc_t data;
    for (int i = 0; i < n; i++)
    begin
        @(negedge w_bus_clk);
        data      = adc_t'($urandom);
        adc_data  = data;
        adc_valid = 1'b1;
        record_pixel(data);
    end
    @(negedge w_bus_clk);
    adc_valid = 1'b0;
endtask

// sixteen pixels, low byte of the low word first
function automatic beat_t pop_beat();
    beat_t b;
    for (int i = 0; i < SAMPLES_PER_BEAT; i++)
        b[i*PIX_W +: PIX_W] = exp_pix.pop_front();
    return b;
endfunction

task automatic start_dma(input sdram_adr_t adr, input sdram_adr_t size);
    @(negedge w_bus_clk);
    sdram_mem.delete();
    base_accepted = accepted;
    base_done     = dma_done_cnt;
    cur_adr       = adr;
    cur_size      = size;
    dma_start_adr = adr;
    dma_buf_size  = size;
    dma_on        = 1'b1;
endtask

task automatic finish_dma(input int n_beats);
    int         cyc;
    beat_t      exp_beat;
    sdram_adr_t a;
    cyc = 0;
    while (accepted < base_accepted + n_beats)
    begin
        if (cyc == DRAIN_LIMIT)
            abort_run("the DMA did not write all expected beats in time");
        @(negedge w_bus_clk);
        cyc++;
    end
    @(negedge w_bus_clk);
    dma_on = 1'b0;
    idle_cycles(20);                                // no extra beat may follow
    check_value("accepted beats", accepted - base_accepted, n_beats);
    check_value("dma_done_cnt", dma_done_cnt, int'(base_done) + n_beats / int'(cur_size));
    for (int k = 0; k < n_beats; k++)
    begin
        exp_beat = pop_beat();
        if (k >= n_beats - int'(cur_size))          // older passes are overwritten
        begin
            a = cur_adr + sdram_adr_t'(k) % cur_size;
            if (!sdram_mem.exists(a))
                abort_run($sformatf("no beat was written at address 0x%0h", a));
            check_value($sformatf("sdram_writedata @0x%0h", a), sdram_mem[a], exp_beat);
        end
    end
endtask

////////////////////////////////////////////////////////////////////////////
// tests

task automatic check_reset_state();
    idle_cycles(1);
    check_value("sdram_write", sdram_write, 1'b0);
    check_value("pix_ovr", pix_ovr, 1'b0);
    check_value("word_afull", word_afull, 1'b0);
    check_value("dma_done_cnt", dma_done_cnt, '0);
endtask

task automatic run_stream(input test_mode_t mode, input int n_samples,
                          input sdram_adr_t adr, input sdram_adr_t size);
    exp_pix.delete();
    @(negedge w_bus_clk);
    test_mode = mode;
    start_dma(adr, size);
    send_samples(n_samples);
    finish_dma(n_samples / SAMPLES_PER_BEAT);
endtask

task automatic test_backpressure();
    int held;
    int words_afull;
    int words_ovr;
    held        = BEAT_FIFO_DEPTH * WORDS_PER_BEAT + WORDS_PER_BEAT - 1;  // beat fifo + assembler
    words_afull = held + PIX_FIFO_AFULL;
    words_ovr   = held + PIX_FIFO_DEPTH + 1;
    exp_pix.delete();
    @(negedge w_bus_clk);
    test_mode = MODE_ADC;
    send_samples((words_afull - 1) * PIX_PER_WORD);
    idle_cycles(4);
    check_value("word_afull", word_afull, 1'b0);
    send_samples(PIX_PER_WORD);
    idle_cycles(4);
    check_value("word_afull", word_afull, 1'b1);
    send_samples((words_ovr - words_afull - 1) * PIX_PER_WORD);
    idle_cycles(4);
    check_value("pix_ovr", pix_ovr, 1'b0);
    send_samples(PIX_PER_WORD);                     // this word is dropped
    idle_cycles(4);
    check_value("pix_ovr", pix_ovr, 1'b1);
    idle_cycles(50);
    check_value("pix_ovr", pix_ovr, 1'b1);
    start_dma(28'h0000600, 28'd64);
    finish_dma((words_ovr - 1) / WORDS_PER_BEAT);   // three words stay in the assembler
    apply_reset();
    check_reset_state();
endtask

initial
begin
    void'($urandom(SEED));
    w_adc_rst         = 1'b1;
    adc_data          = '0;
    adc_valid         = 1'b0;
    test_mode         = MODE_ADC;
    dma_on            = 1'b0;
    dma_start_adr     = '0;
    dma_buf_size      = 28'd64;
    sdram_waitrequest = 1'b0;
    accepted          = 0;
    apply_reset();
    check_reset_state();
    run_stream(MODE_ADC, 64, 28'h0000100, 28'd64);
    run_stream(MODE_RAMP, 16, 28'h0000200, 28'd64);
    run_stream(MODE_CHECKER, 16, 28'h0000300, 28'd64);
    run_stream(MODE_ZERO, 16, 28'h0000400, 28'd64);
    run_stream(MODE_ADC, 192, 28'h0000500, 28'd4);  // ring of 4, three passes
    test_backpressure();
    $display("ALL CHECKS PASSED");
    $finish;
end

initial
begin
    repeat (WATCHDOG_CYCLES) @(posedge w_bus_clk);
    abort_run("timeout, the tests did not finish in the expected time");
end

endmodule
